//--- nocOutputPort.f
hw/nocPkg.sv
hw/flitLink.sv
hw/inputFifo.sv
hw/packetTimer.sv
hw/portArbiter.sv
hw/outputStage.sv
hw/nocOutputPort.sv
bench/nocOutputPort_checker.sv
bench/nocOutputPortTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the output port testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -j 0 --top-module nocOutputPortTb -f nocOutputPort.f \
  > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/VnocOutputPortTb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "ALL CHECKS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- bench/nocOutputPortTb.sv
`timescale 1ns/1ps

module nocOutputPortTb;
  import nocPkg::*;

  localparam int CYCLE = 20;
  localparam int PACKETS = 15 + 20 + 10 + 20;
  localparam int MAX_FLITS = PACKETS * 7;

  logic clk;
  logic rst;
  logic [NUM_PORTS-1:0] inValid;
  flit [NUM_PORTS-1:0] inFlit;
  logic [NUM_PORTS-1:0] inCredit;
  logic outValid;
  flit outFlit;
  logic outCredit;

  logic [31:0] lfsr = 32'he065_42fa;
  // Upstream send queues and the expected flits per port.
  flit txQ [NUM_PORTS][$];
  flit refQ [NUM_PORTS][$];
  portIdx srcOrder [$];
  int upCredit [NUM_PORTS];
  int pendingCredit = 0;
  bit withhold = 1'b0;
  bit backPressure = 1'b0;
  bit randomSend = 1'b0;
  int flitsIn = 0;
  int flitsOut = 0;
  int creditPulses = 0;
  int totalFlits = 0;
  int curPort = -1;
  int remaining = 0;
  int errors = 0;
  int passed = 0;
  int failed = 0;

  nocOutputPort dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CYCLE / 2) clk = ~clk;
  end

  function automatic logic [15:0] randBits(int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic checkFlit(string name, flit got, flit exp);
    if (got !== exp)
    begin
      $display("ERROR time %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkPort(string name, portIdx got, portIdx exp);
    if (got !== exp)
    begin
      $display("ERROR time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkCount(string name, int got, int exp);
    if (got != exp)
    begin
      $display("ERROR time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // Head carries the source port as its destination so that sources stay distinct.
  task automatic queuePacket(int port, int len);
    flit f;
    f.kind = FLIT_HEAD;
    f.payload.head.dest = 4'(port);
    f.payload.head.length = LEN_WIDTH'(len);
    txQ[port].push_back(f);
    refQ[port].push_back(f);
    for (int i = 1; i <= len; i++)
    begin
      f.kind = (i == len) ? FLIT_TAIL : FLIT_BODY;
      f.payload.data = randBits(16);
      txQ[port].push_back(f);
      refQ[port].push_back(f);
    end
    totalFlits += len + 1;
  endtask

  task automatic checkOutput();
    flit exp;
    int src;
    if (curPort < 0)
    begin
      src = -1;
      for (int p = NUM_PORTS - 1; p >= 0; p--)
        if (refQ[p].size() != 0 && refQ[p][0] === outFlit && outFlit.kind == FLIT_HEAD)
          src = p;
      if (src < 0)
      begin
        $display("Time %0t: output flit %h does not start any queued packet", $time, outFlit);
        errors++;
        return;
      end
      curPort = src;
      remaining = int'(outFlit.payload.head.length) + 1;
      srcOrder.push_back(portIdx'(src));
    end
    exp = refQ[curPort].pop_front();
    checkFlit("outFlit", outFlit, exp);
    remaining--;
    if (remaining == 0)
      curPort = -1;
  endtask

  // Outputs seen here were registered at the last rising edge.
  task automatic serviceLinks();
    for (int p = 0; p < NUM_PORTS; p++)
      if (inCredit[p])
      begin
        upCredit[p]++;
        creditPulses++;
      end
    if (outValid)
    begin
      pendingCredit++;
      flitsOut++;
      checkOutput();
    end
    inValid = '0;
    for (int p = 0; p < NUM_PORTS; p++)
      if (txQ[p].size() != 0 && upCredit[p] > 0 && (!randomSend || randBits(1) != '0))
      begin
        inValid[p] = 1'b1;
        inFlit[p] = txQ[p].pop_front();
        upCredit[p]--;
        flitsIn++;
      end
    outCredit = 1'b0;
    if (pendingCredit > 0 && !withhold && (!backPressure || randBits(2) == '0))
    begin
      outCredit = 1'b1;
      pendingCredit--;
    end
  endtask

  function automatic bit drained();
    foreach (refQ[p])
      if (refQ[p].size() != 0)
        return 1'b0;
    return curPort < 0 && pendingCredit == 0;
  endfunction

  task automatic waitDrain(string name);
    int limit;
    int cycles;
    limit = (totalFlits - flitsOut) * 40 + 100;
    cycles = 0;
    while (!drained() && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!drained())
    begin
      $display("Test %s did not drain within %0d cycles", name, limit);
      errors++;
    end
  endtask

  task automatic checkOrder(int first);
    checkCount("packets out", srcOrder.size(), NUM_PORTS);
    foreach (srcOrder[i])
      checkPort("source port", srcOrder[i], portIdx'((first + i) % NUM_PORTS));
  endtask

  task automatic finishTest(string name, int errBefore);
    repeat (2) @(posedge clk);
    checkCount("flits out", flitsOut, flitsIn);
    checkCount("inCredit pulses", creditPulses, flitsIn);
    for (int p = 0; p < NUM_PORTS; p++)
      checkCount($sformatf("upCredit[%0d]", p), upCredit[p], BUF_DEPTH);
    if (errors == errBefore)
    begin
      passed++;
      $display("Test %s passed", name);
    end
    else
    begin
      failed++;
      $display("Test %s failed with %0d errors", name, errors - errBefore);
    end
  endtask

  // Link models start once reset is released.
  initial
  begin
    wait (!rst);
    forever
    begin
      @(posedge clk);
      #2;
      serviceLinks();
    end
  end

  initial
  begin
    repeat (MAX_FLITS * 40 + 1000) @(posedge clk);
    $display("Watchdog expired, the simulation stopped making progress");
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    int e;
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    outCredit = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
      upCredit[p] = BUF_DEPTH;
    repeat (16) @(posedge clk);
    #2 rst = 1'b0;
    @(posedge clk);

    e = errors;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      srcOrder.delete();
      for (int k = 0; k < 3; k++)
        queuePacket(p, int'(randBits(3)) % 7);
      waitDrain("singlePort");
      checkCount("packets out", srcOrder.size(), 3);
    end
    finishTest("singlePort", e);

    e = errors;
    randomSend = 1'b1;
    for (int k = 0; k < 20; k++)
      queuePacket(int'(randBits(3)) % NUM_PORTS, int'(randBits(3)) % 7);
    waitDrain("noInterleave");
    randomSend = 1'b0;
    finishTest("noInterleave", e);

    // Round one from idle, round two while E holds the grant.
    e = errors;
    srcOrder.delete();
    withhold = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
      queuePacket(p, int'(randBits(2)));
    repeat (20) @(posedge clk);
    withhold = 1'b0;
    waitDrain("rotatingPriority");
    checkOrder(0);
    srcOrder.delete();
    withhold = 1'b1;
    queuePacket(2, 6);
    repeat (10) @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
      if (p != 2)
        queuePacket(p, int'(randBits(2)));
    repeat (10) @(posedge clk);
    withhold = 1'b0;
    waitDrain("rotatingPriority");
    checkOrder(2);
    finishTest("rotatingPriority", e);

    e = errors;
    randomSend = 1'b1;
    backPressure = 1'b1;
    for (int k = 0; k < 20; k++)
      queuePacket(int'(randBits(3)) % NUM_PORTS, int'(randBits(3)) % 7);
    waitDrain("backPressure");
    randomSend = 1'b0;
    backPressure = 1'b0;
    finishTest("backPressure", e);

    if (dut0.chk0.fault)
    begin
      $display("A bound assertion failed during the run");
      errors++;
    end
    $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- bench/nocOutputPort_checker.sv
`timescale 1ns/1ps

module nocOutputPortChecker (
  input logic clk,
  input logic rst,
  input logic [nocPkg::NUM_PORTS-1:0] inValid,
  input logic [nocPkg::NUM_PORTS-1:0] inCredit,
  input logic outValid,
  input logic outCredit,
  input logic [nocPkg::NUM_PORTS:0] grant
);
  import nocPkg::*;

  int downCredits;
  int upCredits [NUM_PORTS];
  logic [NUM_PORTS-1:0] canSend;
  bit sendFault = 1'b0;
  bit acceptFault = 1'b0;
  bit grantFault = 1'b0;
  logic fault;

  assign fault = sendFault | acceptFault | grantFault;

  // Credits held by the DUT output and by each upstream sender.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      downCredits <= BUF_DEPTH;
      for (int i = 0; i < NUM_PORTS; i++)
        upCredits[i] <= BUF_DEPTH;
    end
    else
    begin
      downCredits <= downCredits - int'(outValid) + int'(outCredit);
      for (int i = 0; i < NUM_PORTS; i++)
        upCredits[i] <= upCredits[i] - int'(inValid[i]) + int'(inCredit[i]);
    end
  end

  // A credit pulse in the same cycle may be spent at once.
  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
      canSend[i] = (upCredits[i] + int'(inCredit[i])) > 0;
  end

  sendHasCredit: assert property (@(posedge clk) disable iff (rst)
    outValid |-> downCredits > 0)
  else
  begin
    $error("output flit sent with no downstream credit");
    sendFault = 1'b1;
  end

  acceptHasCredit: assert property (@(posedge clk) disable iff (rst)
    !(|(inValid & ~canSend)))
  else
  begin
    $error("input flit arrived on a port with no credit left");
    acceptFault = 1'b1;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
  else
  begin
    $error("arbiter grant is not one-hot");
    grantFault = 1'b1;
  end

endmodule

bind nocOutputPort nocOutputPortChecker chk0 (
  .clk(clk),
  .rst(rst),
  .inValid(inValid),
  .inCredit(inCredit),
  .outValid(outValid),
  .outCredit(outCredit),
  .grant(grant)
);

//--- hw/nocOutputPort.sv
`timescale 1ns/1ps

module nocOutputPort (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::NUM_PORTS-1:0] inValid,
  input  nocPkg::flit [nocPkg::NUM_PORTS-1:0] inFlit,
  output logic [nocPkg::NUM_PORTS-1:0] inCredit,
  output logic outValid,
  output nocPkg::flit outFlit,
  input  logic outCredit
);
  import nocPkg::*;

  flitLink inLink [NUM_PORTS] ();
  flitLink outLink ();

  flit [NUM_PORTS-1:0] heads;
  logic [NUM_PORTS-1:0] nonEmpty;
  logic [NUM_PORTS-1:0] pop;
  logic [NUM_PORTS-1:0] headPop;
  logic [NUM_PORTS-1:0][LEN_WIDTH-1:0] headLength;
  logic [NUM_PORTS:0] grant;
  portIdx grantIdx;
  logic grantValid;

  genvar i;
  generate
    for (i = 0; i < NUM_PORTS; i++)
    begin : gLink
      assign inLink[i].valid = inValid[i];
      assign inLink[i].kind = inFlit[i].kind;
      assign inLink[i].payload = inFlit[i].payload;
      assign inCredit[i] = inLink[i].credit;
      assign headLength[i] = heads[i].payload.head.length;
      assign headPop[i] = pop[i] && (heads[i].kind == FLIT_HEAD);
    end
  endgenerate

  // Port order L, N, E, W, S.
  inputFifo fifoL (.clk(clk), .rst(rst), .link(inLink[0]), .pop(pop[0]),
                   .head(heads[0]), .nonEmpty(nonEmpty[0]));
  inputFifo fifoN (.clk(clk), .rst(rst), .link(inLink[1]), .pop(pop[1]),
                   .head(heads[1]), .nonEmpty(nonEmpty[1]));
  inputFifo fifoE (.clk(clk), .rst(rst), .link(inLink[2]), .pop(pop[2]),
                   .head(heads[2]), .nonEmpty(nonEmpty[2]));
  inputFifo fifoW (.clk(clk), .rst(rst), .link(inLink[3]), .pop(pop[3]),
                   .head(heads[3]), .nonEmpty(nonEmpty[3]));
  inputFifo fifoS (.clk(clk), .rst(rst), .link(inLink[4]), .pop(pop[4]),
                   .head(heads[4]), .nonEmpty(nonEmpty[4]));

  portArbiter arb0 (.clk(clk), .rst(rst), .request(nonEmpty), .headLength(headLength),
                    .forward(pop), .forwardHead(|headPop), .grant(grant),
                    .grantIdx(grantIdx), .grantValid(grantValid));

  outputStage out0 (.clk(clk), .rst(rst), .heads(heads), .nonEmpty(nonEmpty),
                    .grantIdx(grantIdx), .grantValid(grantValid), .pop(pop),
                    .out(outLink));

  assign outValid = outLink.valid;
  assign outFlit = {outLink.kind, outLink.payload};
  assign outLink.credit = outCredit;

endmodule

//--- hw/outputStage.sv
`timescale 1ns/1ps

module outputStage (
  input  logic clk,
  input  logic rst,
  input  nocPkg::flit [nocPkg::NUM_PORTS-1:0] heads,
  input  logic [nocPkg::NUM_PORTS-1:0] nonEmpty,
  input  nocPkg::portIdx grantIdx,
  input  logic grantValid,
  output logic [nocPkg::NUM_PORTS-1:0] pop,
  flitLink.tx out
);
  import nocPkg::*;

  logic [CREDIT_WIDTH-1:0] credits;
  flit selected;
  logic send;

  assign selected = heads[grantIdx];
  assign send = grantValid && nonEmpty[grantIdx] && (credits != '0);

  always_comb
  begin
    pop = '0;
    pop[grantIdx] = send;
  end

  // Credit is spent at the pop, so a flit in flight is already paid for.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      credits <= CREDIT_WIDTH'(BUF_DEPTH);
      out.valid <= 1'b0;
    end
    else
    begin
      out.valid <= send;
      case ({send, out.credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    out.kind <= send ? selected.kind : FLIT_IDLE;
    if (send)
      out.payload <= selected.payload;
  end

endmodule

//--- hw/portArbiter.sv
`timescale 1ns/1ps

module portArbiter (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::NUM_PORTS-1:0] request,
  input  logic [nocPkg::NUM_PORTS-1:0][nocPkg::LEN_WIDTH-1:0] headLength,
  input  logic [nocPkg::NUM_PORTS-1:0] forward,
  input  logic forwardHead,
  output logic [nocPkg::NUM_PORTS:0] grant,
  output nocPkg::portIdx grantIdx,
  output logic grantValid
);
  import nocPkg::*;

  logic [NUM_PORTS:0] nextGrant;
  portIdx nextIdx;
  logic [NUM_PORTS-1:0] done;
  logic handOff;

  genvar i;
  generate
    for (i = 0; i < NUM_PORTS; i++)
    begin : gTimer
      packetTimer timer0 (
        .clk(clk),
        .rst(rst),
        .loadLength(forward[i] & forwardHead),
        .length(headLength[i]),
        .step(forward[i] & ~forwardHead),
        .done(done[i])
      );
    end
  endgenerate

  // Bit 0 is idle, bit n+1 is port n.
  assign handOff = grant[0] | done[grantIdx];
  assign grantValid = ~grant[0];

  always_comb
  begin
    int base;
    int span;
    int pos;
    logic found;
    nextGrant = grant;
    nextIdx = grantIdx;
    found = 1'b0;
    pos = 0;
    // From idle scan all ports from L. Otherwise start after the finished port.
    base = grant[0] ? 0 : int'(grantIdx) + 1;
    span = grant[0] ? NUM_PORTS : NUM_PORTS - 1;
    if (handOff)
    begin
      nextGrant = '0;
      nextGrant[0] = 1'b1;
      for (int k = 0; k < NUM_PORTS; k++)
      begin
        pos = (base + k) % NUM_PORTS;
        if (!found && k < span && request[pos])
        begin
          found = 1'b1;
          nextGrant = '0;
          nextGrant[pos + 1] = 1'b1;
          nextIdx = portIdx'(pos);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= (NUM_PORTS + 1)'(1);
      grantIdx <= '0;
    end
    else
    begin
      grant <= nextGrant;
      grantIdx <= nextIdx;
    end
  end

endmodule

//--- hw/packetTimer.sv
`timescale 1ns/1ps

module packetTimer (
  input  logic clk,
  input  logic rst,
  input  logic loadLength,
  input  logic [nocPkg::LEN_WIDTH-1:0] length,
  input  logic step,
  output logic done
);
  import nocPkg::*;

  logic [LEN_WIDTH-1:0] target;
  logic [LEN_WIDTH-1:0] count;
  logic [LEN_WIDTH-1:0] countNext;

  // Count including a flit forwarded this cycle.
  assign countNext = count + 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      target <= '0;
      count <= '0;
    end
    else if (loadLength)
    begin
      target <= length;
      count <= '0;
    end
    else if (step)
    begin
      count <= countNext;
    end
  end

  // High while the last flit of the packet is forwarded.
  assign done = loadLength ? (length == '0) : (step && countNext == target);

endmodule

//--- hw/inputFifo.sv
`timescale 1ns/1ps

module inputFifo (
  input  logic clk,
  input  logic rst,
  flitLink.rx link,
  input  logic pop,
  output nocPkg::flit head,
  output logic nonEmpty
);
  import nocPkg::*;

  flit mem [BUF_DEPTH];
  logic [PTR_WIDTH-1:0] rdPtr;
  logic [PTR_WIDTH-1:0] wrPtr;
  logic [CREDIT_WIDTH-1:0] fill;
  logic popNow;

  assign popNow = pop & nonEmpty;
  assign head = mem[rdPtr];
  assign nonEmpty = (fill != '0);

  // Sender holds credits, so a valid flit always has a free slot.
  always_ff @(posedge clk)
  begin
    if (link.valid)
      mem[wrPtr] <= {link.kind, link.payload};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      fill <= '0;
      link.credit <= 1'b0;
    end
    else
    begin
      if (link.valid)
        wrPtr <= wrPtr + 1'b1;
      if (popNow)
        rdPtr <= rdPtr + 1'b1;
      case ({link.valid, popNow})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Credit goes back the cycle after the pop.
      link.credit <= popNow;
    end
  end

endmodule

//--- hw/flitLink.sv
`timescale 1ns/1ps

interface flitLink;
  import nocPkg::*;

  logic valid;
  flitKind kind;
  flitPayload payload;
  // One pulse per freed buffer slot.
  logic credit;

  modport tx (
    output valid,
    output kind,
    output payload,
    input  credit
  );

  modport rx (
    input  valid,
    input  kind,
    input  payload,
    output credit
  );

endinterface

//--- hw/nocPkg.sv
package nocPkg;

  localparam int NUM_PORTS = 5;
  localparam int BUF_DEPTH = 4;
  localparam int LEN_WIDTH = 12;
  localparam int PTR_WIDTH = $clog2(BUF_DEPTH);
  // Wide enough to hold BUF_DEPTH itself.
  localparam int CREDIT_WIDTH = $clog2(BUF_DEPTH + 1);

  typedef enum logic [2:0] {
    FLIT_IDLE = 3'd0,
    FLIT_HEAD = 3'd1,
    FLIT_BODY = 3'd2,
    FLIT_TAIL = 3'd3
  } flitKind;

  // Length counts the flits after the header.
  typedef struct packed {
    logic [3:0] dest;
    logic [LEN_WIDTH-1:0] length;
  } headFields;

  // Header fields on a head flit, raw data otherwise.
  typedef union packed {
    headFields head;
    logic [15:0] data;
  } flitPayload;

  typedef struct packed {
    flitKind kind;
    flitPayload payload;
  } flit;

  typedef logic [2:0] portIdx;

endpackage
